/* logic/matMulPkg.sv */
package matMulPkg;

    // matrix geometry, capped at 4 x 4
    localparam int maxDim = 4;
    localparam int matCells = maxDim * maxDim;
    // cycles from raddr to valid rdata
    localparam int readLatency = 2;
    // first result word in external memory
    localparam int resultBase = 32;

    localparam int addrWidth = 16;
    localparam int dataWidth = 16;
    localparam int accWidth = 32;
    localparam int dimWidth = 3;

    typedef logic [dataWidth-1:0] elem_t;
    typedef logic [accWidth-1:0] acc_t;
    typedef logic [addrWidth-1:0] addr_t;
    // legal values 1 to maxDim
    typedef logic [dimWidth-1:0] dim_t;
    typedef logic [$clog2(maxDim)-1:0] idx_t;

    typedef struct packed {
        // rows of A
        dim_t size1;
        // shared inner dimension
        dim_t size2;
        // columns of B
        dim_t size3;
    } matDims_t;

    // one row of A or one column of B, lane 0 in the low bits
    typedef elem_t [maxDim-1:0] lanes_t;

    // single write into the operand store
    typedef struct packed {
        logic en;
        logic selB;
        idx_t row;
        idx_t col;
        elem_t data;
    } storeWr_t;

    // finished element on its way to the result buffer
    typedef struct packed {
        logic en;
        logic [$clog2(matCells)-1:0] idx;
        acc_t data;
    } resWr_t;

    typedef enum logic [1:0] {csFetch, csAccumulate, csStore, csDone} calcState_t;
    typedef enum logic [1:0] {dsIdle, dsMultiply, dsSum} dotState_t;

endpackage

/* logic/memReader.sv */
`timescale 1ns/1ps

module memReader (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          startR,
    input  matMulPkg::dim_t               size1,
    input  matMulPkg::dim_t               size2,
    input  matMulPkg::dim_t               size3,
    input  logic [matMulPkg::accWidth-1:0] rdata,
    output logic                          ren,
    output matMulPkg::addr_t              raddr,
    output matMulPkg::matDims_t           dims,
    output matMulPkg::storeWr_t           storeWr,
    output logic                          finishR
);
    import matMulPkg::*;

    // word counts reach 2 * matCells, one bit above the largest index
    typedef logic [$clog2(2 * matCells + 1)-1:0] cnt_t;

    logic latched;
    cnt_t aWords;
    cnt_t totalWords;
    cnt_t retIdx;
    cnt_t offB;
    // word indices in flight, oldest at the top
    logic pendValid [readLatency];
    cnt_t pendIdx [readLatency];

    // A words first, B words follow directly
    assign aWords = dims.size1 * dims.size2;
    assign totalWords = aWords + dims.size2 * dims.size3;
    assign retIdx = pendIdx[readLatency-1];
    assign offB = retIdx - aWords;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latched <= 1'b0;
            ren <= 1'b0;
            finishR <= 1'b0;
            for (int s = 0; s < readLatency; s++) begin
                pendValid[s] <= 1'b0;
            end
        end else begin
            // sizes taken once, address 0 goes out next cycle
            if (startR && !latched) begin
                latched <= 1'b1;
                ren <= 1'b1;
            end else if (ren && cnt_t'(raddr) == totalWords - cnt_t'(1)) begin
                ren <= 1'b0;
            end
            pendValid[0] <= ren;
            for (int s = 1; s < readLatency; s++) begin
                pendValid[s] <= pendValid[s-1];
            end
            // last word lands this edge
            if (pendValid[readLatency-1] && retIdx == totalWords - cnt_t'(1)) begin
                finishR <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startR && !latched) begin
            dims <= '{size1, size2, size3};
            raddr <= '0;
        end else if (ren) begin
            raddr <= raddr + addr_t'(1);
        end
        pendIdx[0] <= cnt_t'(raddr);
        for (int s = 1; s < readLatency; s++) begin
            pendIdx[s] <= pendIdx[s-1];
        end
    end

    // returning word to matrix coordinates
    always_comb begin
        storeWr.en = pendValid[readLatency-1];
        storeWr.data = rdata[dataWidth-1:0];
        if (retIdx < aWords) begin
            storeWr.selB = 1'b0;
            storeWr.row = idx_t'(retIdx / cnt_t'(dims.size2));
            storeWr.col = idx_t'(retIdx % cnt_t'(dims.size2));
        end else begin
            // B rows are size3 wide
            storeWr.selB = 1'b1;
            storeWr.row = idx_t'(offB / cnt_t'(dims.size3));
            storeWr.col = idx_t'(offB % cnt_t'(dims.size3));
        end
    end

endmodule

/* logic/operandStore.sv */
`timescale 1ns/1ps

module operandStore (
    input  logic                clk,
    input  logic                rst,
    input  matMulPkg::storeWr_t storeWr,
    input  matMulPkg::idx_t     row,
    input  matMulPkg::idx_t     col,
    output matMulPkg::lanes_t   rowLanes,
    output matMulPkg::lanes_t   colLanes
);
    import matMulPkg::*;

    // full maxDim x maxDim grids, unused cells stay zero
    elem_t matA [maxDim][maxDim];
    elem_t matB [maxDim][maxDim];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // zeros beyond size2 keep the unused lanes out of the sum
            for (int r = 0; r < maxDim; r++) begin
                for (int c = 0; c < maxDim; c++) begin
                    matA[r][c] <= '0;
                    matB[r][c] <= '0;
                end
            end
        end else if (storeWr.en) begin
            if (storeWr.selB) begin
                matB[storeWr.row][storeWr.col] <= storeWr.data;
            end else begin
                matA[storeWr.row][storeWr.col] <= storeWr.data;
            end
        end
    end

    // lane k pairs A[row][k] with B[k][col]
    always_comb begin
        for (int k = 0; k < maxDim; k++) begin
            rowLanes[k] = matA[row][k];
            colLanes[k] = matB[k][col];
        end
    end

endmodule

/* logic/dotProductUnit.sv */
`timescale 1ns/1ps

module dotProductUnit (
    input  logic              clk,
    input  logic              rst,
    input  logic              dotStart,
    input  matMulPkg::dim_t   inner,
    input  matMulPkg::lanes_t rowLanes,
    input  matMulPkg::lanes_t colLanes,
    output matMulPkg::acc_t   dotSum,
    output logic              dotDone
);
    import matMulPkg::*;

    dotState_t state;
    idx_t step;
    acc_t prod [maxDim];
    logic lastStep;

    // step counts the product being added this cycle
    assign lastStep = {1'b0, step} == inner - dim_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= dsIdle;
            step <= '0;
            dotDone <= 1'b0;
        end else begin
            // single-cycle pulse
            dotDone <= 1'b0;
            case (state)
                dsIdle: begin
                    step <= '0;
                    if (dotStart) begin
                        state <= dsMultiply;
                    end
                end
                dsMultiply, dsSum: begin
                    if (lastStep) begin
                        dotDone <= 1'b1;
                        state <= dsIdle;
                    end else begin
                        step <= step + idx_t'(1);
                        state <= dsSum;
                    end
                end
                default: begin
                    state <= dsIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // all lanes multiplied at once, products held for the sum
        if (state == dsIdle && dotStart) begin
            for (int k = 0; k < maxDim; k++) begin
                prod[k] <= rowLanes[k] * colLanes[k];
            end
        end
        // first step loads, later steps add, wraps mod 2^32
        if (state == dsMultiply) begin
            dotSum <= prod[step];
        end else if (state == dsSum) begin
            dotSum <= dotSum + prod[step];
        end
    end

endmodule

/* logic/calcSequencer.sv */
`timescale 1ns/1ps

module calcSequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                startC,
    input  logic                finishR,
    input  matMulPkg::matDims_t dims,
    output matMulPkg::idx_t     row,
    output matMulPkg::idx_t     col,
    output logic                dotStart,
    input  logic                dotDone,
    input  matMulPkg::acc_t     dotSum,
    output matMulPkg::resWr_t   resWr,
    output logic                finishC
);
    import matMulPkg::*;

    calcState_t state;
    logic lastCol;
    logic lastRow;

    assign lastCol = {1'b0, col} == dims.size3 - dim_t'(1);
    assign lastRow = {1'b0, row} == dims.size1 - dim_t'(1);

    // operands must all be in the store before the first fetch
    assign dotStart = state == csFetch && startC && finishR;

    // sum stays on dotSum until the next dotStart
    always_comb begin
        resWr.en = state == csStore;
        // row-major slot i * size3 + j
        resWr.idx = row * dims.size3 + col;
        resWr.data = dotSum;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= csFetch;
            row <= '0;
            col <= '0;
            finishC <= 1'b0;
        end else begin
            case (state)
                csFetch: begin
                    if (dotStart) begin
                        state <= csAccumulate;
                    end
                end
                // products summing in the dot unit
                csAccumulate: begin
                    if (dotDone) begin
                        state <= csStore;
                    end
                end
                csStore: begin
                    if (lastCol) begin
                        col <= '0;
                        row <= row + idx_t'(1);
                    end else begin
                        col <= col + idx_t'(1);
                    end
                    if (lastCol && lastRow) begin
                        finishC <= 1'b1;
                        state <= csDone;
                    end else begin
                        state <= csFetch;
                    end
                end
                // parked until reset
                default: begin
                    state <= csDone;
                end
            endcase
        end
    end

endmodule

/* logic/resultWriter.sv */
`timescale 1ns/1ps

module resultWriter (
    input  logic                clk,
    input  logic                rst,
    input  matMulPkg::resWr_t   resWr,
    input  logic                startW,
    input  logic                finishC,
    input  matMulPkg::matDims_t dims,
    output logic                wen,
    output matMulPkg::addr_t    waddr,
    output matMulPkg::acc_t     wdata,
    output logic                finishW
);
    import matMulPkg::*;

    // counts up to matCells inclusive
    typedef logic [$clog2(matCells + 1)-1:0] cnt_t;

    acc_t resBuf [matCells];
    cnt_t sent;
    cnt_t total;
    logic active;
    logic allSent;

    assign total = dims.size1 * dims.size3;
    assign active = startW && finishC && !finishW;
    assign allSent = sent == total;

    // filled by the sequencer, row-major
    always_ff @(posedge clk) begin
        if (resWr.en) begin
            resBuf[resWr.idx] <= resWr.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wen <= 1'b0;
            finishW <= 1'b0;
            sent <= '0;
        end else if (active) begin
            // wen drops as finishW rises
            if (allSent) begin
                wen <= 1'b0;
                finishW <= 1'b1;
            end else begin
                wen <= 1'b1;
                sent <= sent + cnt_t'(1);
            end
        end
    end

    // one word per cycle from resultBase up
    always_ff @(posedge clk) begin
        if (active && !allSent) begin
            waddr <= addr_t'(resultBase) + addr_t'(sent);
            wdata <= resBuf[sent[$clog2(matCells)-1:0]];
        end
    end

endmodule

/* logic/matMulTop.sv */
`timescale 1ns/1ps

module matMulTop (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           startR,
    input  logic                           startC,
    input  logic                           startW,
    input  matMulPkg::dim_t                size1,
    input  matMulPkg::dim_t                size2,
    input  matMulPkg::dim_t                size3,
    input  logic [matMulPkg::accWidth-1:0] rdata,
    output logic                           ren,
    output matMulPkg::addr_t               raddr,
    output logic                           finishR,
    output logic                           finishC,
    output logic                           finishW,
    output logic                           wen,
    output matMulPkg::addr_t               waddr,
    output matMulPkg::acc_t                wdata
);
    import matMulPkg::*;

    // sizes latched by the reader at startR
    matDims_t dims;
    storeWr_t storeWr;
    idx_t row;
    idx_t col;
    lanes_t rowLanes;
    lanes_t colLanes;
    logic dotStart;
    logic dotDone;
    acc_t dotSum;
    resWr_t resWr;

    // read phase, memory into the operand store
    memReader reader_i (
        .clk(clk), .rst(rst), .startR(startR),
        .size1(size1), .size2(size2), .size3(size3),
        .rdata(rdata), .ren(ren), .raddr(raddr),
        .dims(dims), .storeWr(storeWr), .finishR(finishR)
    );

    operandStore store_i (
        .clk(clk), .rst(rst), .storeWr(storeWr), .row(row), .col(col),
        .rowLanes(rowLanes), .colLanes(colLanes)
    );

    // inner length is size2
    dotProductUnit dot_i (
        .clk(clk), .rst(rst), .dotStart(dotStart), .inner(dims.size2),
        .rowLanes(rowLanes), .colLanes(colLanes),
        .dotSum(dotSum), .dotDone(dotDone)
    );

    calcSequencer seq_i (
        .clk(clk), .rst(rst), .startC(startC), .finishR(finishR),
        .dims(dims), .row(row), .col(col), .dotStart(dotStart),
        .dotDone(dotDone), .dotSum(dotSum), .resWr(resWr), .finishC(finishC)
    );

    // write phase, result buffer out to memory
    resultWriter writer_i (
        .clk(clk), .rst(rst), .resWr(resWr), .startW(startW),
        .finishC(finishC), .dims(dims), .wen(wen), .waddr(waddr),
        .wdata(wdata), .finishW(finishW)
    );

endmodule

/* testbench/memModel.sv */
`timescale 1ns/1ps

module memModel (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ren,
    input  matMulPkg::addr_t               raddr,
    output logic [matMulPkg::accWidth-1:0] rdata,
    input  logic                           wen,
    input  matMulPkg::addr_t               waddr,
    input  matMulPkg::acc_t                wdata
);
    import matMulPkg::*;

    // operands at 0 up, results from resultBase
    logic [accWidth-1:0] mem [resultBase + matCells];
    // first of the two read stages
    logic [accWidth-1:0] stage;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            stage <= '0;
            rdata <= '0;
        end else begin
            if (ren) begin
                stage <= mem[raddr];
            end
            // valid two edges after raddr is sampled
            rdata <= stage;
        end
    end

    // registered write port
    always @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

/* testbench/matMulTb.sv */
`timescale 1ns/1ps

module matMulTb;
    import matMulPkg::*;

    logic clk;
    logic rst;
    logic startR;
    logic startC;
    logic startW;
    dim_t size1;
    dim_t size2;
    dim_t size3;
    logic [accWidth-1:0] rdata;
    logic ren;
    addr_t raddr;
    logic finishR;
    logic finishC;
    logic finishW;
    logic wen;
    addr_t waddr;
    acc_t wdata;

    // operand copies for the reference model
    elem_t opA [maxDim][maxDim];
    elem_t opB [maxDim][maxDim];
    integer seed;
    int errors;
    int timeouts;
    // reads and writes seen since reset
    int rdCount;
    int wrCount;

    matMulTop dut_i (
        .clk(clk), .rst(rst), .startR(startR), .startC(startC), .startW(startW),
        .size1(size1), .size2(size2), .size3(size3), .rdata(rdata),
        .ren(ren), .raddr(raddr), .finishR(finishR), .finishC(finishC),
        .finishW(finishW), .wen(wen), .waddr(waddr), .wdata(wdata)
    );

    memModel mem_i (
        .clk(clk), .rst(rst), .ren(ren), .raddr(raddr), .rdata(rdata),
        .wen(wen), .waddr(waddr), .wdata(wdata)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // sum over k of A[i][k] * B[k][j] wrapping at 32 bits
    function automatic acc_t matMulRef(input int i, input int j, input int inner);
        acc_t sum;
        sum = '0;
        for (int k = 0; k < inner; k++) begin
            sum = sum + acc_t'(opA[i][k]) * acc_t'(opB[k][j]);
        end
        return sum;
    endfunction

    task automatic checkAcc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // bus monitor sampled on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rdCount = 0;
            wrCount = 0;
        end else begin
            // addresses go out in order, each once
            if (ren) begin
                checkAddr("raddr", raddr, addr_t'(rdCount));
                rdCount++;
            end
            if (finishR) begin
                checkLevel("ren after finishR", ren, 1'b0);
            end
            if (wen) begin
                checkAddr("waddr", waddr, addr_t'(resultBase + wrCount));
                wrCount++;
            end
            if (finishW) begin
                checkLevel("wen after finishW", wen, 1'b0);
            end
        end
    end

    task automatic endRun();
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    function automatic logic finishLevel(input int sel);
        case (sel)
            0: return finishR;
            1: return finishC;
            default: return finishW;
        endcase
    endfunction

    // 2000-cycle limit per phase
    task automatic waitFinish(input string name, input int sel);
        int cycles;
        cycles = 0;
        while (finishLevel(sel) !== 1'b1 && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (finishLevel(sel) !== 1'b1) begin
            $display("timeout: %s did not rise within 2000 cycles", name);
            timeouts++;
        end
    endtask

    // one full read, calculate, write pass after a fresh reset
    task automatic runTest(input int s1, input int s2, input int s3, input bit allOnes);
        int baseB;
        baseB = s1 * s2;
        @(negedge clk);
        rst = 1'b1;
        startR = 1'b0;
        startC = 1'b0;
        startW = 1'b0;
        size1 = dim_t'(s1);
        size2 = dim_t'(s2);
        size3 = dim_t'(s3);
        // fill tied to the full address
        for (int a = 0; a < resultBase + matCells; a++) begin
            mem_i.mem[a] = 32'hc0de0000 | a;
        end
        for (int r = 0; r < maxDim; r++) begin
            for (int c = 0; c < maxDim; c++) begin
                opA[r][c] = allOnes ? 16'hffff : elem_t'($random(seed) & 16'hffff);
                opB[r][c] = allOnes ? 16'hffff : elem_t'($random(seed) & 16'hffff);
            end
        end
        // row-major, B right after A
        for (int r = 0; r < s1; r++) begin
            for (int c = 0; c < s2; c++) begin
                mem_i.mem[r * s2 + c] = {16'h0000, opA[r][c]};
            end
        end
        for (int r = 0; r < s2; r++) begin
            for (int c = 0; c < s3; c++) begin
                mem_i.mem[baseB + r * s3 + c] = {16'h0000, opB[r][c]};
            end
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // idle levels before any start
        checkLevel("ren", ren, 1'b0);
        checkLevel("wen", wen, 1'b0);
        checkLevel("finishR", finishR, 1'b0);
        checkLevel("finishC", finishC, 1'b0);
        checkLevel("finishW", finishW, 1'b0);
        startR = 1'b1;
        waitFinish("finishR", 0);
        startR = 1'b0;
        checkAddr("read count", addr_t'(rdCount), addr_t'(baseB + s2 * s3));
        startC = 1'b1;
        waitFinish("finishC", 1);
        startC = 1'b0;
        startW = 1'b1;
        waitFinish("finishW", 2);
        startW = 1'b0;
        // wen must stay quiet for a while
        repeat (4) @(negedge clk);
        checkAddr("write count", addr_t'(wrCount), addr_t'(s1 * s3));
        for (int i = 0; i < s1; i++) begin
            for (int j = 0; j < s3; j++) begin
                checkAcc($sformatf("result[%0d][%0d]", i, j),
                         mem_i.mem[resultBase + i * s3 + j], matMulRef(i, j, s2));
            end
        end
    endtask

    initial begin
        seed = 32'hf0a7;
        errors = 0;
        timeouts = 0;
        clk = 1'b0;
        rst = 1'b1;
        startR = 1'b0;
        startC = 1'b0;
        startW = 1'b0;
        size1 = dim_t'(1);
        size2 = dim_t'(1);
        size3 = dim_t'(1);
        runTest(4, 4, 4, 1'b0);
        // non-square and smallest shapes
        runTest(2, 3, 4, 1'b0);
        runTest(1, 1, 1, 1'b0);
        // all ones wraps the 32-bit sum
        runTest(4, 4, 4, 1'b1);
        endRun();
    end

endmodule

/* matMul.f */
logic/matMulPkg.sv
logic/memReader.sv
logic/operandStore.sv
logic/dotProductUnit.sv
logic/calcSequencer.sv
logic/resultWriter.sv
logic/matMulTop.sv
testbench/memModel.sv
testbench/matMulTb.sv
